// File: common/fsync_consts.svh
// Widths, port counts and register-file size
// Signature base per level, level-4 sentinel and the sd "both" code
`ifndef FSYNC_CONSTS_SVH
`define FSYNC_CONSTS_SVH

`define FSYNC_LEVEL_WIDTH 2 // Four levels, stored as level-1
`define FSYNC_ID_WIDTH 3 // Barrier id
`define FSYNC_SD_WIDTH 2 // Back-routing code

`define FSYNC_N_H_PORTS 2 // Horizontal side
`define FSYNC_N_V_PORTS 2 // Vertical side

`define FSYNC_N_DM_REGS 10 // Entries per side
`define FSYNC_SIG_WIDTH 4 // Index into the entries

// Signature base of each level, lowest level first
`define FSYNC_LVL_BASE_1 0
`define FSYNC_LVL_BASE_2 1
`define FSYNC_LVL_BASE_3 2
`define FSYNC_LVL_BASE_4 6
`define FSYNC_LVL_SENTINEL 10 // Upper bound for level 4

`define FSYNC_SD_BOTH 2'b11 // Route back to both sides

`endif

// File: common/fsync_pkg.sv
// Shared types for the barrier remote register file
// Level, id, local id, sd, signature and per-port flags
`include "fsync_consts.svh"

package fsync_pkg;

  // Level is encoded as level minus one
  typedef logic [`FSYNC_LEVEL_WIDTH-1:0] fsync_level_t;

  typedef logic [`FSYNC_ID_WIDTH-1:0] fsync_id_t;

  // Barrier id with its lowest bit dropped
  typedef logic [`FSYNC_ID_WIDTH-2:0] fsync_local_id_t;

  typedef logic [`FSYNC_SD_WIDTH-1:0] fsync_sd_t; // Source/destination code

  typedef logic [`FSYNC_SIG_WIDTH-1:0] fsync_sig_t; // Register index

  // Combinational status of one request port
  typedef struct packed {
    logic sig_err; // Out-of-range signature on a pending port
    logic bypass; // First of several ports on one id
    logic ignore; // Later ports on the same id
  } fsync_flags_t;

endpackage

// File: common/fsync_req_if.sv
// Request bundle of one side: level, id, sd and the two strobes
`timescale 1ns/1ps

interface fsync_req_if #(
  parameter int unsigned N_PORTS = 2
);
  import fsync_pkg::*;

  fsync_level_t level [N_PORTS]; // Level minus one
  fsync_id_t id [N_PORTS];
  fsync_sd_t sd [N_PORTS]; // Back-routing code
  logic check [N_PORTS]; // Look up a stored barrier
  logic set [N_PORTS]; // Store or complete a barrier

  // Driven from the top-level ports
  modport src (
    output level, id, sd, check, set
  );

  // Signature generator and control block
  modport dst (
    input level, id, sd, check, set
  );

endinterface

// File: common/fsync_cmd_if.sv
// Command bundle of one side towards the register file
`timescale 1ns/1ps

interface fsync_cmd_if #(
  parameter int unsigned N_PORTS = 2
);
  import fsync_pkg::*;

  logic check [N_PORTS]; // Gated check
  logic set [N_PORTS]; // Gated set
  fsync_sd_t sd [N_PORTS]; // Forced to both on bypass/ignore
  fsync_sig_t sig [N_PORTS]; // Entry index
  logic sig_valid [N_PORTS]; // Index within the level's range

  modport ctrl (
    output check, set, sd
  );

  modport sig_src (
    output sig, sig_valid
  );

  modport rf (
    input check, set, sd, sig, sig_valid
  );

endinterface

// File: hdl/fsync_sig_gen.sv
// Per-port signature generator
// Level base lookup, local id addition and range check
`timescale 1ns/1ps
`include "fsync_consts.svh"

module fsync_sig_gen #(
  parameter int unsigned N_PORTS = 2
) (
  fsync_req_if.dst req_i,
  fsync_cmd_if.sig_src cmd_o
);
  import fsync_pkg::*;

  localparam int unsigned SUM_WIDTH = `FSYNC_SIG_WIDTH + 1; // Headroom for the sentinel
  localparam int unsigned MAX_SIG = `FSYNC_N_DM_REGS - 1;

  // One base per level plus the sentinel as the base after level 4
  localparam logic [SUM_WIDTH-1:0] LVL_BASE [5] = '{
    SUM_WIDTH'(`FSYNC_LVL_BASE_1),
    SUM_WIDTH'(`FSYNC_LVL_BASE_2),
    SUM_WIDTH'(`FSYNC_LVL_BASE_3),
    SUM_WIDTH'(`FSYNC_LVL_BASE_4),
    SUM_WIDTH'(`FSYNC_LVL_SENTINEL)
  };

  fsync_local_id_t local_id [N_PORTS];
  logic [`FSYNC_LEVEL_WIDTH:0] next_lvl [N_PORTS]; // One bit wider to reach the sentinel
  logic [SUM_WIDTH-1:0] base [N_PORTS];
  logic [SUM_WIDTH-1:0] next_base [N_PORTS];
  logic [SUM_WIDTH-1:0] sum [N_PORTS];

  for (genvar p = 0; p < N_PORTS; p++) begin : gen_sig
    assign local_id[p] = req_i.id[p][`FSYNC_ID_WIDTH-1:1]; // Drop the side bit
    assign next_lvl[p] = {1'b0, req_i.level[p]} + 1'b1;
    assign base[p] = LVL_BASE[req_i.level[p]];
    assign next_base[p] = LVL_BASE[next_lvl[p]];
    assign sum[p] = base[p] + SUM_WIDTH'(local_id[p]);

    assign cmd_o.sig[p] = sum[p][`FSYNC_SIG_WIDTH-1:0]; // Truncated index
    // Inside the table and below the next level's base
    assign cmd_o.sig_valid[p] = (sum[p] <= SUM_WIDTH'(MAX_SIG)) && (sum[p] < next_base[p]);
  end

endmodule

// File: remote_rf/fsync_rf_ctrl.sv
// Per-side control: signature errors, same-id arbitration
// and gating of the strobes into register-file commands
`timescale 1ns/1ps
`include "fsync_consts.svh"

module fsync_rf_ctrl #(
  parameter int unsigned N_PORTS = 2
) (
  fsync_req_if.dst req_i,
  input logic sig_valid_i [N_PORTS],
  fsync_cmd_if.ctrl cmd_o,
  output fsync_pkg::fsync_flags_t flags_o [N_PORTS]
);
  import fsync_pkg::*;

  localparam int unsigned N_LOCAL_IDS = 2 ** $bits(fsync_local_id_t);

  fsync_local_id_t local_id [N_PORTS];
  logic [N_PORTS-1:0] pending; // Check or set asserted
  logic [N_PORTS-1:0] match [N_LOCAL_IDS]; // Local id against port
  logic [N_PORTS-1:0] first [N_LOCAL_IDS]; // Lowest claimant per id
  logic [N_LOCAL_IDS-1:0] shared; // Id named by more than one port
  logic [N_PORTS-1:0] bypass;
  logic [N_PORTS-1:0] ignore;

  for (genvar p = 0; p < N_PORTS; p++) begin : gen_pending
    assign local_id[p] = req_i.id[p][`FSYNC_ID_WIDTH-1:1];
    assign pending[p] = req_i.check[p] | req_i.set[p];
  end

  // Match matrix and priority pick, scanned from port 0 upwards
  always_comb begin : arb
    logic found;
    found = 1'b0;
    for (int i = 0; i < N_LOCAL_IDS; i++) begin
      found = 1'b0;
      for (int j = 0; j < N_PORTS; j++) begin
        match[i][j] = pending[j] && (local_id[j] == fsync_local_id_t'(i));
        first[i][j] = match[i][j] && !found; // Only the lowest pending port
        found = found | match[i][j];
      end
      shared[i] = |(match[i] & ~first[i]); // Somebody besides the first
    end
  end

  // Fold the per-id decisions back onto the ports
  always_comb begin : fold
    for (int j = 0; j < N_PORTS; j++) begin
      bypass[j] = 1'b0;
      ignore[j] = 1'b0;
      for (int i = 0; i < N_LOCAL_IDS; i++) begin
        bypass[j] = bypass[j] | (first[i][j] & shared[i]);
        ignore[j] = ignore[j] | (match[i][j] & ~first[i][j]);
      end
    end
  end

  for (genvar p = 0; p < N_PORTS; p++) begin : gen_cmd
    assign flags_o[p].sig_err = ~sig_valid_i[p] & pending[p];
    assign flags_o[p].bypass = bypass[p];
    assign flags_o[p].ignore = ignore[p];

    // Collided ports route the answer back to both directions
    assign cmd_o.sd[p] = (bypass[p] | ignore[p]) ? fsync_sd_t'(`FSYNC_SD_BOTH) : req_i.sd[p];
    assign cmd_o.check[p] = req_i.check[p] & ~(bypass[p] | ignore[p]);
    assign cmd_o.set[p] = req_i.set[p] & ~ignore[p]; // Bypass still stores
  end

endmodule

// File: remote_rf/fsync_dm_rf.sv
// Directly mapped multi-port register file
// One present bit and one stored sd per entry, answer one cycle later
`timescale 1ns/1ps

module fsync_dm_rf #(
  parameter int unsigned N_PORTS = 2,
  parameter int unsigned N_REGS = 10
) (
  input logic clk_i,
  input logic reset_i,
  fsync_cmd_if.rf cmd_i,
  output logic present_o [N_PORTS],
  output fsync_pkg::fsync_sd_t sd_o [N_PORTS]
);
  import fsync_pkg::*;

  logic [N_REGS-1:0] present_q; // Entry holds a barrier
  fsync_sd_t sd_q [N_REGS]; // Stored back-routing code

  logic [N_PORTS-1:0] cmd_vld; // Valid index with check or set
  logic [N_PORTS-1:0] hit; // Entry full, answer and clear
  logic [N_PORTS-1:0] store; // Set on an empty entry

  always_comb begin
    for (int p = 0; p < N_PORTS; p++) begin
      cmd_vld[p] = cmd_i.sig_valid[p] & (cmd_i.check[p] | cmd_i.set[p]);
      hit[p] = 1'b0;
      store[p] = 1'b0;
      if (cmd_vld[p]) begin
        hit[p] = present_q[cmd_i.sig[p]];
        store[p] = cmd_i.set[p] & ~present_q[cmd_i.sig[p]];
      end
    end
  end

  // Present bits and responses; ports never share an entry in a cycle
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      present_q <= '0;
      for (int p = 0; p < N_PORTS; p++) begin
        present_o[p] <= 1'b0;
        sd_o[p] <= '0;
      end
    end else begin
      for (int p = 0; p < N_PORTS; p++) begin
        present_o[p] <= hit[p];
        sd_o[p] <= hit[p] ? sd_q[cmd_i.sig[p]] : '0; // Zero unless the barrier was there
        if (hit[p]) begin
          present_q[cmd_i.sig[p]] <= 1'b0; // Barrier completes
        end else if (store[p]) begin
          present_q[cmd_i.sig[p]] <= 1'b1; // First arrival waits
        end
      end
    end
  end

  // Stored sd, only meaningful while present is set
  always_ff @(posedge clk_i) begin
    for (int p = 0; p < N_PORTS; p++) begin
      if (store[p]) begin
        sd_q[cmd_i.sig[p]] <= cmd_i.sd[p];
      end
    end
  end

endmodule

// File: hdl/fsync_2d_remote_rf.sv
// Two-dimensional remote register file top level
// Horizontal and vertical sides, each with signature, control and storage
`timescale 1ns/1ps
`include "fsync_consts.svh"

module fsync_2d_remote_rf (
  input logic clk_i,
  input logic reset_i,

  input fsync_pkg::fsync_level_t level_h_i [`FSYNC_N_H_PORTS],
  input fsync_pkg::fsync_id_t id_h_i [`FSYNC_N_H_PORTS],
  input fsync_pkg::fsync_sd_t sd_h_i [`FSYNC_N_H_PORTS],
  input logic check_h_i [`FSYNC_N_H_PORTS],
  input logic set_h_i [`FSYNC_N_H_PORTS],
  output logic h_present_o [`FSYNC_N_H_PORTS],
  output fsync_pkg::fsync_sd_t h_sd_o [`FSYNC_N_H_PORTS],
  output logic h_sig_err_o [`FSYNC_N_H_PORTS],
  output logic h_bypass_o [`FSYNC_N_H_PORTS],
  output logic h_ignore_o [`FSYNC_N_H_PORTS],

  input fsync_pkg::fsync_level_t level_v_i [`FSYNC_N_V_PORTS],
  input fsync_pkg::fsync_id_t id_v_i [`FSYNC_N_V_PORTS],
  input fsync_pkg::fsync_sd_t sd_v_i [`FSYNC_N_V_PORTS],
  input logic check_v_i [`FSYNC_N_V_PORTS],
  input logic set_v_i [`FSYNC_N_V_PORTS],
  output logic v_present_o [`FSYNC_N_V_PORTS],
  output fsync_pkg::fsync_sd_t v_sd_o [`FSYNC_N_V_PORTS],
  output logic v_sig_err_o [`FSYNC_N_V_PORTS],
  output logic v_bypass_o [`FSYNC_N_V_PORTS],
  output logic v_ignore_o [`FSYNC_N_V_PORTS]
);
  import fsync_pkg::*;

  fsync_flags_t h_flags [`FSYNC_N_H_PORTS];
  fsync_flags_t v_flags [`FSYNC_N_V_PORTS];

  // Horizontal side
  fsync_req_if #(.N_PORTS(`FSYNC_N_H_PORTS)) h_req ();
  fsync_cmd_if #(.N_PORTS(`FSYNC_N_H_PORTS)) h_cmd ();

  assign h_req.level = level_h_i;
  assign h_req.id = id_h_i;
  assign h_req.sd = sd_h_i;
  assign h_req.check = check_h_i;
  assign h_req.set = set_h_i;

  fsync_sig_gen #(.N_PORTS(`FSYNC_N_H_PORTS)) i_sig_gen_h (
    .req_i (h_req),
    .cmd_o (h_cmd)
  );

  fsync_rf_ctrl #(.N_PORTS(`FSYNC_N_H_PORTS)) i_rf_ctrl_h (
    .req_i       (h_req),
    .sig_valid_i (h_cmd.sig_valid),
    .cmd_o       (h_cmd),
    .flags_o     (h_flags)
  );

  fsync_dm_rf #(
    .N_PORTS (`FSYNC_N_H_PORTS),
    .N_REGS  (`FSYNC_N_DM_REGS)
  ) i_dm_rf_h (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .cmd_i     (h_cmd),
    .present_o (h_present_o),
    .sd_o      (h_sd_o)
  );

  for (genvar p = 0; p < `FSYNC_N_H_PORTS; p++) begin : gen_h_flags
    assign h_sig_err_o[p] = h_flags[p].sig_err;
    assign h_bypass_o[p] = h_flags[p].bypass;
    assign h_ignore_o[p] = h_flags[p].ignore;
  end

  // Vertical side, own entries
  fsync_req_if #(.N_PORTS(`FSYNC_N_V_PORTS)) v_req ();
  fsync_cmd_if #(.N_PORTS(`FSYNC_N_V_PORTS)) v_cmd ();

  assign v_req.level = level_v_i;
  assign v_req.id = id_v_i;
  assign v_req.sd = sd_v_i;
  assign v_req.check = check_v_i;
  assign v_req.set = set_v_i;

  fsync_sig_gen #(.N_PORTS(`FSYNC_N_V_PORTS)) i_sig_gen_v (
    .req_i (v_req),
    .cmd_o (v_cmd)
  );

  fsync_rf_ctrl #(.N_PORTS(`FSYNC_N_V_PORTS)) i_rf_ctrl_v (
    .req_i       (v_req),
    .sig_valid_i (v_cmd.sig_valid),
    .cmd_o       (v_cmd),
    .flags_o     (v_flags)
  );

  fsync_dm_rf #(
    .N_PORTS (`FSYNC_N_V_PORTS),
    .N_REGS  (`FSYNC_N_DM_REGS)
  ) i_dm_rf_v (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .cmd_i     (v_cmd),
    .present_o (v_present_o),
    .sd_o      (v_sd_o)
  );

  for (genvar p = 0; p < `FSYNC_N_V_PORTS; p++) begin : gen_v_flags
    assign v_sig_err_o[p] = v_flags[p].sig_err;
    assign v_bypass_o[p] = v_flags[p].bypass;
    assign v_ignore_o[p] = v_flags[p].ignore;
  end

endmodule

// File: dv/fsync_rf_checker.sv
// Bound assertions for both sides of the remote register file
// Flag exclusivity, response cause and no response after a signature error
`timescale 1ns/1ps
`include "fsync_consts.svh"

module fsync_rf_checker (
  input logic clk_i,
  input logic reset_i,
  input logic check_h_i [`FSYNC_N_H_PORTS],
  input logic set_h_i [`FSYNC_N_H_PORTS],
  input logic h_present_o [`FSYNC_N_H_PORTS],
  input logic h_sig_err_o [`FSYNC_N_H_PORTS],
  input logic h_bypass_o [`FSYNC_N_H_PORTS],
  input logic h_ignore_o [`FSYNC_N_H_PORTS],
  input logic check_v_i [`FSYNC_N_V_PORTS],
  input logic set_v_i [`FSYNC_N_V_PORTS],
  input logic v_present_o [`FSYNC_N_V_PORTS],
  input logic v_sig_err_o [`FSYNC_N_V_PORTS],
  input logic v_bypass_o [`FSYNC_N_V_PORTS],
  input logic v_ignore_o [`FSYNC_N_V_PORTS]
);

  int unsigned fail_count; // Failed assertions so far

  initial begin
    fail_count = 0;
  end

  for (genvar p = 0; p < `FSYNC_N_H_PORTS; p++) begin : gen_h
    a_h_one_role: assert property (@(posedge clk_i) disable iff (reset_i)
      !(h_bypass_o[p] && h_ignore_o[p])) // A port is first or later but never both
      else begin
        fail_count++;
        $error("h port %0d has bypass and ignore high together", p);
      end
    a_h_present_cause: assert property (@(posedge clk_i) disable iff (reset_i)
      h_present_o[p] |-> $past(check_h_i[p] || set_h_i[p]))
      else begin
        fail_count++;
        $error("h port %0d answered present without a strobe", p);
      end
    a_h_err_quiet: assert property (@(posedge clk_i) disable iff (reset_i)
      h_sig_err_o[p] |=> !h_present_o[p]) // Bad index never reaches the entries
      else begin
        fail_count++;
        $error("h port %0d answered present after a signature error", p);
      end
  end

  for (genvar p = 0; p < `FSYNC_N_V_PORTS; p++) begin : gen_v
    a_v_one_role: assert property (@(posedge clk_i) disable iff (reset_i)
      !(v_bypass_o[p] && v_ignore_o[p]))
      else begin
        fail_count++;
        $error("v port %0d has bypass and ignore high together", p);
      end
    a_v_present_cause: assert property (@(posedge clk_i) disable iff (reset_i)
      v_present_o[p] |-> $past(check_v_i[p] || set_v_i[p]))
      else begin
        fail_count++;
        $error("v port %0d answered present without a strobe", p);
      end
    a_v_err_quiet: assert property (@(posedge clk_i) disable iff (reset_i)
      v_sig_err_o[p] |=> !v_present_o[p])
      else begin
        fail_count++;
        $error("v port %0d answered present after a signature error", p);
      end
  end

endmodule

// File: dv/fsync_tb.sv
// Testbench for the two-dimensional remote register file
// Random requests on both sides, reference model, compare tasks, watchdog
`timescale 1ns/1ps
`include "fsync_consts.svh"

module fsync_tb;
  import fsync_pkg::*;

  localparam int unsigned NH = `FSYNC_N_H_PORTS;
  localparam int unsigned NV = `FSYNC_N_V_PORTS;
  localparam int unsigned NP = (NH > NV) ? NH : NV; // Model rows sized for the wider side
  localparam int unsigned N_REGS = `FSYNC_N_DM_REGS;
  localparam int unsigned PERIOD_NS = 10;
  localparam int unsigned RESET_CYCLES = 10;
  localparam int unsigned RUN_CYCLES = 2000;
  // Two reset phases and two runs with a factor of two as margin
  localparam int unsigned TIMEOUT_NS = 2 * (2 * (RESET_CYCLES + RUN_CYCLES) + 2) * PERIOD_NS;
  localparam int unsigned LVL_BASES [5] = '{`FSYNC_LVL_BASE_1, `FSYNC_LVL_BASE_2,
    `FSYNC_LVL_BASE_3, `FSYNC_LVL_BASE_4, `FSYNC_LVL_SENTINEL};

  logic clk_i;
  logic reset_i;
  fsync_level_t level_h_i [NH];
  fsync_id_t id_h_i [NH];
  fsync_sd_t sd_h_i [NH];
  logic check_h_i [NH];
  logic set_h_i [NH];
  logic h_present_o [NH];
  fsync_sd_t h_sd_o [NH];
  logic h_sig_err_o [NH];
  logic h_bypass_o [NH];
  logic h_ignore_o [NH];
  fsync_level_t level_v_i [NV];
  fsync_id_t id_v_i [NV];
  fsync_sd_t sd_v_i [NV];
  logic check_v_i [NV];
  logic set_v_i [NV];
  logic v_present_o [NV];
  fsync_sd_t v_sd_o [NV];
  logic v_sig_err_o [NV];
  logic v_bypass_o [NV];
  logic v_ignore_o [NV];

  integer seed;
  logic mdl_present [2][N_REGS]; // Side 0 is h and side 1 is v
  fsync_sd_t mdl_sd [2][N_REGS];
  logic exp_present [2][NP]; // Due at the next falling edge
  fsync_sd_t exp_sd [2][NP];
  fsync_level_t stim_level [2][NP]; // Requests of the current cycle
  fsync_id_t stim_id [2][NP];
  fsync_sd_t stim_sd [2][NP];
  logic stim_check [2][NP];
  logic stim_set [2][NP];

  fsync_2d_remote_rf i_fsync_2d_remote_rf (.*);

  bind fsync_2d_remote_rf fsync_rf_checker i_fsync_rf_checker (.*);

  initial begin : clock
    clk_i = 1'b0;
    forever #(PERIOD_NS / 2) clk_i = ~clk_i;
  end

  function automatic int unsigned port_count(input int side);
    return (side == 0) ? NH : NV;
  endfunction

  function automatic logic pending_port(input int side, input int p);
    return stim_check[side][p] | stim_set[side][p];
  endfunction

  // Base of the level plus the local id and its range check
  function automatic void signature(input fsync_level_t level, input fsync_id_t id,
                                    output int unsigned sig, output logic valid);
    sig = LVL_BASES[level] + int'(id >> 1);
    valid = (sig <= N_REGS - 1) && (sig < LVL_BASES[int'(level) + 1]);
  endfunction

  function automatic fsync_flags_t expected_flags(input int side, input int port);
    fsync_flags_t f;
    int unsigned sig;
    logic valid;
    f = '0;
    if (pending_port(side, port)) begin
      signature(stim_level[side][port], stim_id[side][port], sig, valid);
      f.sig_err = !valid;
      for (int k = 0; k < port_count(side); k++) begin
        if (k != port && pending_port(side, k) &&
            (stim_id[side][k] >> 1) == (stim_id[side][port] >> 1)) begin
          if (k < port) begin
            f.ignore = 1'b1; // A lower port claims the id
          end else begin
            f.bypass = 1'b1; // Shared with a higher port
          end
        end
      end
      if (f.ignore) begin
        f.bypass = 1'b0;
      end
    end
    return f;
  endfunction

  task automatic report_mismatch(input string msg);
    $display("CHECK FAILED at %0t ns: %s", $time, msg);
    $display("Simulation finished: FAIL");
    $fatal(1, "Stopped at the first mismatch");
  endtask

  task automatic check_assertions();
    if (i_fsync_2d_remote_rf.i_fsync_rf_checker.fail_count != 0) begin
      $display("ERROR: a bound assertion failed before %0t ns", $time);
      $display("Simulation finished: FAIL");
      $fatal(1, "Stopped at a failed assertion");
    end
  endtask

  task automatic check_flags(input string what, input fsync_flags_t got,
                             input fsync_flags_t exp);
    if (got !== exp) begin
      report_mismatch($sformatf("%s sig_err/bypass/ignore got %b, expected %b",
                                what, got, exp));
    end
  endtask

  task automatic check_resp(input string what, input logic got_present, input fsync_sd_t got_sd,
                            input logic exp_pres, input fsync_sd_t exp_code);
    if (got_present !== exp_pres || got_sd !== exp_code) begin
      report_mismatch($sformatf("%s present/sd got %b/%b, expected %b/%b",
                                what, got_present, got_sd, exp_pres, exp_code));
    end
  endtask

  task automatic check_responses();
    for (int p = 0; p < NH; p++) begin
      check_resp($sformatf("h port %0d", p), h_present_o[p], h_sd_o[p],
                 exp_present[0][p], exp_sd[0][p]);
    end
    for (int p = 0; p < NV; p++) begin
      check_resp($sformatf("v port %0d", p), v_present_o[p], v_sd_o[p],
                 exp_present[1][p], exp_sd[1][p]);
    end
  endtask

  task automatic check_all_flags();
    for (int p = 0; p < NH; p++) begin
      check_flags($sformatf("h port %0d", p), {h_sig_err_o[p], h_bypass_o[p], h_ignore_o[p]},
                  expected_flags(0, p));
    end
    for (int p = 0; p < NV; p++) begin
      check_flags($sformatf("v port %0d", p), {v_sig_err_o[p], v_bypass_o[p], v_ignore_o[p]},
                  expected_flags(1, p));
    end
  endtask

  task automatic drive_random(input logic rst);
    logic [31:0] r;
    reset_i = rst;
    for (int s = 0; s < 2; s++) begin
      for (int p = 0; p < port_count(s); p++) begin
        r = $random(seed);
        stim_level[s][p] = r[1:0];
        stim_id[s][p] = r[4:2];
        stim_sd[s][p] = r[6:5];
        stim_check[s][p] = r[7];
        stim_set[s][p] = r[8];
        if (p > 0 && r[9]) begin
          stim_id[s][p] = {stim_id[s][0][`FSYNC_ID_WIDTH-1:1], r[10]}; // Force a collision
        end
      end
    end
    for (int p = 0; p < NH; p++) begin
      level_h_i[p] = stim_level[0][p];
      id_h_i[p] = stim_id[0][p];
      sd_h_i[p] = stim_sd[0][p];
      check_h_i[p] = stim_check[0][p];
      set_h_i[p] = stim_set[0][p];
    end
    for (int p = 0; p < NV; p++) begin
      level_v_i[p] = stim_level[1][p];
      id_v_i[p] = stim_id[1][p];
      sd_v_i[p] = stim_sd[1][p];
      check_v_i[p] = stim_check[1][p];
      set_v_i[p] = stim_set[1][p];
    end
  endtask

  // Entry update and expected answer of one side for the coming edge
  task automatic step_model(input int side, input logic rst);
    fsync_flags_t f;
    int unsigned sig;
    logic valid;
    logic do_check;
    logic do_set;
    fsync_sd_t sd_fwd;
    for (int p = 0; p < port_count(side); p++) begin
      exp_present[side][p] = 1'b0;
      exp_sd[side][p] = '0;
      f = expected_flags(side, p);
      signature(stim_level[side][p], stim_id[side][p], sig, valid);
      do_check = stim_check[side][p] && !f.bypass && !f.ignore;
      do_set = stim_set[side][p] && !f.ignore;
      sd_fwd = (f.bypass || f.ignore) ? fsync_sd_t'(`FSYNC_SD_BOTH) : stim_sd[side][p];
      if (!rst && valid && (do_check || do_set)) begin
        if (mdl_present[side][sig]) begin
          exp_present[side][p] = 1'b1; // Second arrival or check completes
          exp_sd[side][p] = mdl_sd[side][sig];
          mdl_present[side][sig] = 1'b0;
        end else if (do_set) begin
          mdl_present[side][sig] = 1'b1; // First arrival waits
          mdl_sd[side][sig] = sd_fwd;
        end
      end
    end
    if (rst) begin
      for (int e = 0; e < N_REGS; e++) begin
        mdl_present[side][e] = 1'b0;
      end
    end
  endtask

  task automatic run_cycles(input int unsigned n, input logic rst);
    for (int unsigned c = 0; c < n; c++) begin
      @(negedge clk_i);
      check_responses(); // Registered at the last rising edge
      check_assertions();
      drive_random(rst);
      #2;
      check_all_flags(); // Combinational and settled well before the edge
      step_model(0, rst);
      step_model(1, rst);
    end
  endtask

  initial begin : stimulus
    seed = 54;
    reset_i = 1'b1;
    for (int s = 0; s < 2; s++) begin
      for (int p = 0; p < NP; p++) begin
        stim_level[s][p] = '0;
        stim_id[s][p] = '0;
        stim_sd[s][p] = '0;
        stim_check[s][p] = 1'b0;
        stim_set[s][p] = 1'b0;
        exp_present[s][p] = 1'b0;
        exp_sd[s][p] = '0;
      end
      for (int e = 0; e < N_REGS; e++) begin
        mdl_present[s][e] = 1'b0;
        mdl_sd[s][e] = '0;
      end
    end
    for (int p = 0; p < NH; p++) begin
      level_h_i[p] = '0;
      id_h_i[p] = '0;
      sd_h_i[p] = '0;
      check_h_i[p] = 1'b0;
      set_h_i[p] = 1'b0;
    end
    for (int p = 0; p < NV; p++) begin
      level_v_i[p] = '0;
      id_v_i[p] = '0;
      sd_v_i[p] = '0;
      check_v_i[p] = 1'b0;
      set_v_i[p] = 1'b0;
    end
    run_cycles(RESET_CYCLES, 1'b1);
    run_cycles(RUN_CYCLES, 1'b0);
    run_cycles(RESET_CYCLES, 1'b1); // Second reset with live strobes clears all entries
    run_cycles(RUN_CYCLES, 1'b0);
    @(negedge clk_i);
    check_responses();
    check_assertions();
    $display("Simulation finished: PASS");
    $finish;
  end

  initial begin : watchdog
    #(TIMEOUT_NS);
    $display("ERROR: watchdog expired after %0d ns, the run did not complete", TIMEOUT_NS);
    $display("Simulation finished: FAIL");
    $fatal(1, "Watchdog timeout");
  end

endmodule

// File: fsync_2d_remote_rf.f
+incdir+common
common/fsync_pkg.sv
common/fsync_req_if.sv
common/fsync_cmd_if.sv
hdl/fsync_sig_gen.sv
remote_rf/fsync_rf_ctrl.sv
remote_rf/fsync_dm_rf.sv
hdl/fsync_2d_remote_rf.sv
dv/fsync_rf_checker.sv
dv/fsync_tb.sv
